/* Makefile */
VERILATOR ?= verilator
TOP       ?= sdCardEmulatorTb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_TEXT ?= Simulation finished: PASS
VFLAGS    ?= --binary --timing -Wno-fatal

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
HEADERS := $(wildcard logic/*.svh)
SIM_BIN := $(BUILD_DIR)/$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR) -o $(TOP)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* logic/cmdReceiver.sv */
`timescale 1ns/1ps
`include "sdCard_defines.svh"

module cmdReceiver (
    input  logic                 clk,
    input  logic                 rst_,
    input  logic                 cmdIn,
    output sdCardPkg::cmdFrame_t frame,
    output logic                 frameValid
);
    import sdCardPkg::*;

    localparam int LAST_BIT = `SD_CMD_BITS - 1;
    localparam int CRC_SPAN = `SD_CMD_BITS - `SD_CRC7_BITS - 1;

    rxState_e                 state;
    logic                     cmdSample;
    logic [`SD_CMD_BITS-2:0]  shiftReg;
    logic [`SD_CMD_BITS-1:0]  fullFrame;
    logic [5:0]               bitCnt;
    logic [`SD_CRC7_BITS-1:0] crcCalc;
    logic                     crcClear;
    logic                     crcEnable;

    // Earlier bits plus the one sampled last
    assign fullFrame = {shiftReg, cmdSample};

    // Start bit is zero and leaves a cleared CRC unchanged
    assign crcClear  = (state == RX_IDLE) && !cmdSample;
    assign crcEnable = (state == RX_SHIFT) && (bitCnt < 6'(CRC_SPAN));

    crc7 rxCrc (
        .clk    (clk),
        .rst_   (rst_),
        .clear  (crcClear),
        .enable (crcEnable),
        .bitIn  (cmdSample),
        .crc    (crcCalc)
    );

    always_ff @(posedge clk) begin
        shiftReg <= {shiftReg[`SD_CMD_BITS-3:0], cmdSample};
    end

    always_ff @(posedge clk) begin
        if (!rst_) begin
            state      <= RX_IDLE;
            cmdSample  <= 1'b1;
            bitCnt     <= '0;
            frameValid <= 1'b0;
        end else begin
            cmdSample  <= cmdIn;
            frameValid <= 1'b0;
            case (state)
                RX_IDLE: begin
                    if (!cmdSample) begin
                        state  <= RX_SHIFT;
                        bitCnt <= 6'd1;
                    end
                end
                RX_SHIFT: begin
                    bitCnt <= bitCnt + 6'd1;
                    if (bitCnt == 6'(LAST_BIT)) begin
                        state      <= RX_IDLE;
                        frameValid <= 1'b1;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // Frame fields, latched together with frameValid
    always_ff @(posedge clk) begin
        if (state == RX_SHIFT && bitCnt == 6'(LAST_BIT)) begin
            frame.index     <= fullFrame[45:40];
            frame.arg       <= fullFrame[39:8];
            frame.crcOk     <= (fullFrame[7:1] == crcCalc);
            frame.framingOk <= fullFrame[46] && fullFrame[0];
        end
    end

endmodule

/* logic/cmdResponder.sv */
`timescale 1ns/1ps
`include "sdCard_defines.svh"

module cmdResponder (
    input  logic                    clk,
    input  logic                    rst_,
    input  sdCardPkg::cmdFrame_t    frame,
    input  logic                    frameValid,
    output sdCardPkg::cmdResponse_t resp,
    output logic                    respLoad,
    output logic                    readStart,
    output logic                    readStop
);
    import sdCardPkg::*;

    logic [15:0] rca;
    logic        acmdFlag;
    logic        selected;
    logic        frameOk;
    sdCmd_e      cmd;

    assign frameOk = frameValid && frame.crcOk && frame.framingOk;
    assign cmd     = sdCmd_e'({acmdFlag, frame.index});

    // =========================================================================
    // Card state and strobes
    // =========================================================================
    always_ff @(posedge clk) begin
        if (!rst_) begin
            rca       <= '0;
            acmdFlag  <= 1'b0;
            selected  <= 1'b0;
            respLoad  <= 1'b0;
            readStart <= 1'b0;
            readStop  <= 1'b0;
        end else begin
            respLoad  <= 1'b0;
            readStart <= 1'b0;
            readStop  <= 1'b0;
            if (frameOk) begin
                // Prefix applies to the next command only
                acmdFlag <= 1'b0;
                case (cmd)
                    CMD0_GO_IDLE: begin
                        rca      <= '0;
                        selected <= 1'b0;
                        readStop <= 1'b1;
                    end
                    CMD3_SEND_RCA: begin
                        rca      <= `SD_CARD_RCA;
                        respLoad <= 1'b1;
                    end
                    CMD7_SELECT: begin
                        if (frame.arg[31:16] == rca) begin
                            selected <= 1'b1;
                            respLoad <= 1'b1;
                        end
                    end
                    CMD55_APP_CMD: begin
                        acmdFlag <= 1'b1;
                        respLoad <= 1'b1;
                    end
                    CMD18_READ_MULTI: begin
                        // Data only flows once the card is selected
                        readStart <= selected;
                        respLoad  <= 1'b1;
                    end
                    CMD12_STOP: begin
                        readStop <= 1'b1;
                        respLoad <= 1'b1;
                    end
                    CMD8_IF_COND, ACMD41_OP_COND: respLoad <= 1'b1;
                    default: ;
                endcase
            end
        end
    end

    // =========================================================================
    // Response contents
    // =========================================================================
    always_ff @(posedge clk) begin
        if (frameOk) begin
            resp.index    <= frame.index;
            resp.fixedCrc <= 1'b0;
            case (cmd)
                CMD3_SEND_RCA: resp.arg <= {`SD_CARD_RCA, `SD_R6_STATUS};
                CMD8_IF_COND:  resp.arg <= {20'd0, frame.arg[11:0]};
                CMD55_APP_CMD: resp.arg <= `SD_APP_STATUS;
                ACMD41_OP_COND: begin
                    // R3 has no index echo and no real CRC
                    resp.index    <= '1;
                    resp.arg      <= `SD_OCR_READY;
                    resp.fixedCrc <= 1'b1;
                end
                default: resp.arg <= `SD_R1_STATUS;
            endcase
        end
    end

endmodule

/* logic/crc16Lanes.sv */
`timescale 1ns/1ps
`include "sdCard_defines.svh"

module crc16Lanes (
    input  logic                 clk,
    input  logic                 rst_,
    input  logic                 clear,
    input  logic                 accumulate,
    input  logic                 shiftOut,
    input  sdCardPkg::datLanes_t dataIn,
    output sdCardPkg::datLanes_t crcMsb
);

    // One CRC16 per DAT lane, polynomial x^16 + x^12 + x^5 + 1
    for (genvar lane = 0; lane < `SD_LANES; lane++) begin : gLane
        logic [`SD_CRC16_BITS-1:0] crcReg;
        logic                      feedback;

        assign feedback = dataIn[lane] ^ crcReg[`SD_CRC16_BITS-1];

        always_ff @(posedge clk) begin
            if (!rst_ || clear) begin
                crcReg <= '0;
            end else if (accumulate) begin
                crcReg <= {crcReg[14:12], crcReg[11] ^ feedback, crcReg[10:5],
                           crcReg[4] ^ feedback, crcReg[3:0], feedback};
            end else if (shiftOut) begin
                crcReg <= crcReg << 1;
            end
        end

        assign crcMsb[lane] = crcReg[`SD_CRC16_BITS-1];
    end

endmodule

/* logic/crc7.sv */
`timescale 1ns/1ps
`include "sdCard_defines.svh"

module crc7 (
    input  logic                     clk,
    input  logic                     rst_,
    input  logic                     clear,
    input  logic                     enable,
    input  logic                     bitIn,
    output logic [`SD_CRC7_BITS-1:0] crc
);

    logic feedback;

    // Polynomial x^7 + x^3 + 1
    assign feedback = bitIn ^ crc[`SD_CRC7_BITS-1];

    always_ff @(posedge clk) begin
        if (!rst_ || clear) begin
            crc <= '0;
        end else if (enable) begin
            crc <= {crc[5:3], crc[2] ^ feedback, crc[1:0], feedback};
        end
    end

endmodule

/* logic/readBlockSender.sv */
`timescale 1ns/1ps
`include "sdCard_defines.svh"

module readBlockSender (
    input  logic                 clk,
    input  logic                 rst_,
    input  logic                 readStart,
    input  logic                 readStop,
    output sdCardPkg::datLanes_t datOut,
    output logic                 datOutEn
);
    import sdCardPkg::*;

    localparam int NIBBLES   = `SD_BLOCK_BYTES * 2;
    localparam int CNT_BITS  = $clog2(NIBBLES);
    localparam int WAIT_LOAD = `SD_NAC_CYCLES - 4;

    blockPhase_e         phase;
    logic [CNT_BITS-1:0] cnt;
    logic [7:0]          blockNum;
    logic [7:0]          byteVal;
    datLanes_t           nibble;
    datLanes_t           crcMsb;

    // Byte k of block b is (k + b) mod 256, high nibble first
    assign byteVal = 8'(cnt[CNT_BITS-1:1]) + blockNum;
    assign nibble  = cnt[0] ? byteVal[3:0] : byteVal[7:4];

    crc16Lanes datCrc (
        .clk        (clk),
        .rst_       (rst_),
        .clear      (phase == BLK_START),
        .accumulate (phase == BLK_DATA),
        .shiftOut   (phase == BLK_CRC),
        .dataIn     (nibble),
        .crcMsb     (crcMsb)
    );

    always_comb begin
        case (phase)
            BLK_START: datOut = '0;
            BLK_DATA:  datOut = nibble;
            BLK_CRC:   datOut = crcMsb;
            default:   datOut = '1;
        endcase
    end

    assign datOutEn = (phase == BLK_START) || (phase == BLK_DATA) ||
                      (phase == BLK_CRC) || (phase == BLK_END);

    always_ff @(posedge clk) begin
        if (!rst_) begin
            phase    <= BLK_IDLE;
            cnt      <= '0;
            blockNum <= '0;
        end else if (readStop) begin
            phase <= BLK_IDLE;
        end else if (readStart) begin
            phase    <= BLK_WAIT;
            cnt      <= CNT_BITS'(WAIT_LOAD);
            blockNum <= '0;
        end else begin
            case (phase)
                BLK_WAIT, BLK_GAP: begin
                    if (cnt == '0) begin
                        phase <= BLK_START;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                BLK_START: begin
                    phase <= BLK_DATA;
                    cnt   <= '0;
                end
                BLK_DATA: begin
                    // Wraps back to zero on the last nibble
                    cnt <= cnt + 1'b1;
                    if (cnt == CNT_BITS'(NIBBLES - 1)) begin
                        phase <= BLK_CRC;
                    end
                end
                BLK_CRC: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == CNT_BITS'(`SD_CRC16_BITS - 1)) begin
                        phase <= BLK_END;
                    end
                end
                BLK_END: begin
                    phase    <= BLK_GAP;
                    cnt      <= CNT_BITS'(`SD_BLOCK_GAP - 1);
                    blockNum <= blockNum + 8'd1;
                end
                default: phase <= BLK_IDLE;
            endcase
        end
    end

endmodule

/* logic/respTransmitter.sv */
`timescale 1ns/1ps
`include "sdCard_defines.svh"

module respTransmitter (
    input  logic                    clk,
    input  logic                    rst_,
    input  sdCardPkg::cmdResponse_t resp,
    input  logic                    respLoad,
    output logic                    cmdOut,
    output logic                    cmdOutEn
);
    import sdCardPkg::*;

    localparam int BODY_BITS = `SD_CMD_BITS - `SD_CRC7_BITS - 1;
    // Receiver, responder and load edge already use three of the NCR edges
    localparam int WAIT_LOAD = `SD_NCR_CYCLES - 4;

    txState_e                 state;
    logic [BODY_BITS-1:0]     shiftReg;
    logic                     fixedCrc;
    logic [5:0]               bitCnt;
    logic [3:0]               waitCnt;
    logic [`SD_CRC7_BITS-1:0] crcCalc;
    logic                     crcBit;

    assign crcBit = fixedCrc ? 1'b1 : crcCalc[3'(`SD_CRC7_BITS - 1) - bitCnt[2:0]];

    crc7 txCrc (
        .clk    (clk),
        .rst_   (rst_),
        .clear  ((state == TX_IDLE) && respLoad),
        .enable (state == TX_BODY),
        .bitIn  (shiftReg[BODY_BITS-1]),
        .crc    (crcCalc)
    );

    always_comb begin
        case (state)
            TX_BODY: cmdOut = shiftReg[BODY_BITS-1];
            TX_CRC:  cmdOut = crcBit;
            default: cmdOut = 1'b1;
        endcase
    end

    assign cmdOutEn = (state == TX_BODY) || (state == TX_CRC) || (state == TX_END);

    // Start and transmission bits are both zero for a card response
    always_ff @(posedge clk) begin
        if (state == TX_IDLE && respLoad) begin
            shiftReg <= {2'b00, resp.index, resp.arg};
            fixedCrc <= resp.fixedCrc;
        end else if (state == TX_BODY) begin
            shiftReg <= shiftReg << 1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_) begin
            state   <= TX_IDLE;
            bitCnt  <= '0;
            waitCnt <= '0;
        end else begin
            case (state)
                TX_IDLE: begin
                    if (respLoad) begin
                        state   <= TX_WAIT;
                        waitCnt <= 4'(WAIT_LOAD);
                    end
                end
                TX_WAIT: begin
                    if (waitCnt == '0) begin
                        state  <= TX_BODY;
                        bitCnt <= '0;
                    end else begin
                        waitCnt <= waitCnt - 4'd1;
                    end
                end
                TX_BODY: begin
                    bitCnt <= bitCnt + 6'd1;
                    if (bitCnt == 6'(BODY_BITS - 1)) begin
                        state  <= TX_CRC;
                        bitCnt <= '0;
                    end
                end
                TX_CRC: begin
                    bitCnt <= bitCnt + 6'd1;
                    if (bitCnt == 6'(`SD_CRC7_BITS - 1)) begin
                        state <= TX_END;
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

endmodule

/* logic/sdCardEmulator.sv */
`timescale 1ns/1ps
`include "sdCard_defines.svh"

module sdCardEmulator (
    input  logic                 clk,
    input  logic                 rst_,
    input  logic                 cmdIn,
    output logic                 cmdOut,
    output logic                 cmdOutEn,
    output sdCardPkg::datLanes_t datOut,
    output logic                 datOutEn
);
    import sdCardPkg::*;

    cmdFrame_t    frame;
    logic         frameValid;
    cmdResponse_t resp;
    logic         respLoad;
    logic         readStart;
    logic         readStop;

    // =========================================================================
    // Command path
    // =========================================================================
    cmdReceiver receiver (
        .clk        (clk),
        .rst_       (rst_),
        .cmdIn      (cmdIn),
        .frame      (frame),
        .frameValid (frameValid)
    );

    cmdResponder responder (
        .clk        (clk),
        .rst_       (rst_),
        .frame      (frame),
        .frameValid (frameValid),
        .resp       (resp),
        .respLoad   (respLoad),
        .readStart  (readStart),
        .readStop   (readStop)
    );

    respTransmitter transmitter (
        .clk      (clk),
        .rst_     (rst_),
        .resp     (resp),
        .respLoad (respLoad),
        .cmdOut   (cmdOut),
        .cmdOutEn (cmdOutEn)
    );

    // Read data on the four DAT lanes
    readBlockSender reader (
        .clk       (clk),
        .rst_      (rst_),
        .readStart (readStart),
        .readStop  (readStop),
        .datOut    (datOut),
        .datOutEn  (datOutEn)
    );

endmodule

/* logic/sdCardPkg.sv */
`include "sdCard_defines.svh"

package sdCardPkg;

    // Top bit marks an application command, low six bits hold the index
    typedef enum logic [6:0] {
        CMD0_GO_IDLE     = 7'd0,
        CMD3_SEND_RCA    = 7'd3,
        CMD7_SELECT      = 7'd7,
        CMD8_IF_COND     = 7'd8,
        CMD12_STOP       = 7'd12,
        CMD18_READ_MULTI = 7'd18,
        CMD55_APP_CMD    = 7'd55,
        ACMD41_OP_COND   = 7'b1_101001
    } sdCmd_e;

    // Received command after framing and CRC checks
    typedef struct packed {
        logic [5:0]  index;
        logic [31:0] arg;
        logic        crcOk;
        logic        framingOk;
    } cmdFrame_t;

    // R3 responses carry all ones in index and CRC
    typedef struct packed {
        logic [5:0]  index;
        logic [31:0] arg;
        logic        fixedCrc;
    } cmdResponse_t;

    typedef logic [`SD_LANES-1:0] datLanes_t;

    typedef enum logic {
        RX_IDLE,
        RX_SHIFT
    } rxState_e;

    typedef enum logic [2:0] {
        TX_IDLE,
        TX_WAIT,
        TX_BODY,
        TX_CRC,
        TX_END
    } txState_e;

    typedef enum logic [2:0] {
        BLK_IDLE,
        BLK_WAIT,
        BLK_START,
        BLK_DATA,
        BLK_CRC,
        BLK_END,
        BLK_GAP
    } blockPhase_e;

endpackage

/* logic/sdCard_defines.svh */
`ifndef SD_CARD_DEFINES_SVH
`define SD_CARD_DEFINES_SVH

// =========================================================================
// Frame and lane geometry
// =========================================================================
`define SD_CMD_BITS     48
`define SD_CRC7_BITS    7
`define SD_CRC16_BITS   16
`define SD_LANES        4
`define SD_BLOCK_BYTES  512

// =========================================================================
// Latencies in clock edges, counted from the edge sampling the end bit
// =========================================================================
`define SD_NCR_CYCLES   4
`define SD_NAC_CYCLES   8
`define SD_BLOCK_GAP    2

// Card address and canned response words
`define SD_CARD_RCA     16'hAAAA
`define SD_R6_STATUS    16'h0520
`define SD_R1_STATUS    32'h0000_0900
`define SD_APP_STATUS   32'h0000_0920
`define SD_OCR_READY    32'hC1FF_8080

`endif

/* test/sdCardEmulatorTb.sv */
`timescale 1ns/1ps
`include "sdCard_defines.svh"

module sdCardEmulatorTb;
    import sdCardPkg::*;

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 8;
    localparam int NIBBLES      = `SD_BLOCK_BYTES * 2;
    localparam int BLOCK_ACTIVE = NIBBLES + `SD_CRC16_BITS + 2;
    localparam int BLOCK_TOTAL  = BLOCK_ACTIVE + `SD_BLOCK_GAP;
    localparam int CMD_BUDGET   = 8 + 2 * `SD_CMD_BITS + `SD_NCR_CYCLES + 2;
    localparam int NUM_COMMANDS = 18;

    logic      clk = 1'b0;
    logic      rst_;
    logic      cmdIn;
    logic      cmdOut;
    logic      cmdOutEn;
    datLanes_t datOut;
    logic      datOutEn;

    integer      seed;
    int          budget = 0;
    logic [15:0] laneCrc [`SD_LANES];

    sdCardEmulator u_dut (
        .clk      (clk),
        .rst_     (rst_),
        .cmdIn    (cmdIn),
        .cmdOut   (cmdOut),
        .cmdOutEn (cmdOutEn),
        .datOut   (datOut),
        .datOutEn (datOutEn)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // =========================================================================
    // Reference model
    // =========================================================================
    function automatic int unsigned randRange(int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    // x^7 + x^3 + 1, MSB first
    function automatic logic [6:0] crc7Of(logic [39:0] bits);
        logic [6:0] c;
        logic       fb;
        c = '0;
        for (int i = 39; i >= 0; i--) begin
            fb = bits[i] ^ c[6];
            c  = {c[5:0], 1'b0} ^ (fb ? 7'h09 : 7'h00);
        end
        return c;
    endfunction

    // Host frame: start 0, transmission 1
    function automatic logic [47:0] buildFrame(logic [5:0] index, logic [31:0] arg);
        logic [39:0] body;
        body = {2'b01, index, arg};
        return {body, crc7Of(body), 1'b1};
    endfunction

    function automatic cmdResponse_t respOf(logic [5:0] index, logic [31:0] arg, logic fixed);
        cmdResponse_t r;
        r.index    = index;
        r.arg      = arg;
        r.fixedCrc = fixed;
        return r;
    endfunction

    function automatic datLanes_t payloadNibble(int b, int n);
        logic [7:0] byteVal;
        byteVal = 8'((n / 2 + b) % 256);
        return (n % 2 == 0) ? byteVal[7:4] : byteVal[3:0];
    endfunction

    // CRC16 of each lane over a whole block
    function automatic void computeBlockCrc(int b);
        datLanes_t nib;
        logic      fb;
        for (int lane = 0; lane < `SD_LANES; lane++) begin
            laneCrc[lane] = '0;
            for (int n = 0; n < NIBBLES; n++) begin
                nib = payloadNibble(b, n);
                fb  = nib[lane] ^ laneCrc[lane][15];
                laneCrc[lane] = {laneCrc[lane][14:0], 1'b0} ^ (fb ? 16'h1021 : 16'h0000);
            end
        end
    endfunction

    // Cycle t of a block: start, payload, CRC16, end
    function automatic datLanes_t expectedDat(int b, int t);
        datLanes_t d;
        d = '1;
        if (t == 0) begin
            d = '0;
        end else if (t <= NIBBLES) begin
            d = payloadNibble(b, t - 1);
        end else if (t <= NIBBLES + `SD_CRC16_BITS) begin
            for (int lane = 0; lane < `SD_LANES; lane++) begin
                d[lane] = laneCrc[lane][NIBBLES + `SD_CRC16_BITS - t];
            end
        end
        return d;
    endfunction

    // =========================================================================
    // Compare tasks
    // =========================================================================
    task automatic failRun(string reason);
        $display("%s", reason);
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic checkBit(string name, logic got, logic exp);
        if (got !== exp) begin
            failRun($sformatf("CHECK FAILED at %0t: %s got %b expected %b",
                              $time, name, got, exp));
        end
    endtask

    task automatic checkDatLanes(string name, datLanes_t got, datLanes_t exp);
        if (got !== exp) begin
            failRun($sformatf("CHECK FAILED at %0t: %s got %b expected %b",
                              $time, name, got, exp));
        end
    endtask

    task automatic checkResponse(string name, cmdResponse_t got, cmdResponse_t exp);
        if (got !== exp) begin
            failRun($sformatf({"CHECK FAILED at %0t: %s got index %0d arg %h fixed %b",
                               " expected index %0d arg %h fixed %b"}, $time, name,
                              got.index, got.arg, got.fixedCrc,
                              exp.index, exp.arg, exp.fixedCrc));
        end
    endtask

    // =========================================================================
    // Host stimulus
    // =========================================================================
    // Returns on the falling edge right after the end bit is sampled
    task automatic sendCommand(logic [47:0] frame);
        for (int i = 47; i >= 0; i--) begin
            @(negedge clk);
            cmdIn = frame[i];
        end
        @(negedge clk);
        cmdIn = 1'b1;
    endtask

    task automatic idleGap();
        repeat (randRange(8)) @(negedge clk);
    endtask

    task automatic quietLines(int cycles);
        repeat (cycles) begin
            @(negedge clk);
            checkBit("cmdOutEn while idle", cmdOutEn, 1'b0);
            checkBit("datOutEn while idle", datOutEn, 1'b0);
        end
    endtask

    task automatic expectSilence();
        repeat (`SD_NCR_CYCLES + `SD_CMD_BITS) begin
            @(negedge clk);
            checkBit("cmdOutEn for ignored command", cmdOutEn, 1'b0);
        end
    endtask

    task automatic receiveResponse(cmdResponse_t exp);
        logic [47:0]  got;
        logic [6:0]   wantCrc;
        cmdResponse_t gotResp;
        cmdResponse_t wantResp;
        wantCrc = exp.fixedCrc ? 7'h7F : crc7Of({2'b00, exp.index, exp.arg});
        repeat (`SD_NCR_CYCLES - 1) begin
            @(negedge clk);
            checkBit("cmdOutEn before response", cmdOutEn, 1'b0);
        end
        for (int i = 47; i >= 0; i--) begin
            @(negedge clk);
            checkBit("cmdOutEn during response", cmdOutEn, 1'b1);
            got[i] = cmdOut;
        end
        @(negedge clk);
        checkBit("cmdOutEn after response", cmdOutEn, 1'b0);
        checkBit("response start bit", got[47], 1'b0);
        checkBit("response transmission bit", got[46], 1'b0);
        gotResp  = respOf(got[45:40], got[39:8], got[7:1] == 7'h7F);
        wantResp = respOf(exp.index, exp.arg, wantCrc == 7'h7F);
        checkResponse("response fields", gotResp, wantResp);
        for (int i = 6; i >= 0; i--) begin
            checkBit($sformatf("response CRC7 bit %0d", i), got[i + 1], wantCrc[i]);
        end
        checkBit("response end bit", got[0], 1'b1);
    endtask

    task automatic runCommand(logic [5:0] index, logic [31:0] arg, cmdResponse_t exp,
                              logic answered);
        idleGap();
        sendCommand(buildFrame(index, arg));
        if (answered) begin
            receiveResponse(exp);
        end else begin
            expectSilence();
        end
    endtask

    task automatic silentFrame(logic [47:0] frame);
        idleGap();
        sendCommand(frame);
        expectSilence();
    endtask

    // Active cycles up to lastActive, released afterwards
    task automatic checkBlock(int b, int lastActive, int cycles);
        computeBlockCrc(b);
        for (int t = 0; t < cycles; t++) begin
            @(negedge clk);
            if (t <= lastActive) begin
                checkBit("datOutEn in block", datOutEn, 1'b1);
                checkDatLanes($sformatf("datOut block %0d cycle %0d", b, t),
                              datOut, expectedDat(b, t));
            end else begin
                checkBit("datOutEn outside block", datOutEn, 1'b0);
            end
        end
    endtask

    task automatic readBlocks(int n);
        idleGap();
        sendCommand(buildFrame(6'd18, $random(seed)));
        fork
            receiveResponse(respOf(6'd18, `SD_R1_STATUS, 1'b0));
            begin
                repeat (`SD_NAC_CYCLES - 1) begin
                    @(negedge clk);
                    checkBit("datOutEn before first block", datOutEn, 1'b0);
                end
                for (int b = 0; b < n; b++) begin
                    checkBlock(b, BLOCK_ACTIVE - 1, BLOCK_TOTAL);
                end
            end
        join
    endtask

    // Command starts d cycles into block b, data ends after E+2
    task automatic stopDuringBlock(logic [5:0] index, int b, int d, logic answered);
        fork
            begin
                repeat (d) @(negedge clk);
                sendCommand(buildFrame(index, 32'h0));
                if (answered) begin
                    receiveResponse(respOf(index, `SD_R1_STATUS, 1'b0));
                end else begin
                    expectSilence();
                end
            end
            checkBlock(b, d + `SD_CMD_BITS + 2, d + `SD_CMD_BITS + 4);
        join
    endtask

    // =========================================================================
    // Test sequence
    // =========================================================================
    initial begin
        int          reads1;
        int          reads2;
        int          stop1;
        int          stop2;
        int unsigned pos;
        int unsigned badIndex;
        logic [31:0] arg8;
        logic [47:0] frame;

        seed   = 32'h8e0a_d3b1;
        rst_   = 1'b0;
        cmdIn  = 1'b1;
        reads1 = 1 + randRange(3);
        reads2 = 1 + randRange(3);
        stop1  = 1 + randRange(900);
        stop2  = 1 + randRange(900);
        budget = RESET_CYCLES + 60 + NUM_COMMANDS * CMD_BUDGET
                 + (reads1 + reads2 + 2) * BLOCK_TOTAL + 2 * `SD_NAC_CYCLES;

        repeat (RESET_CYCLES) @(negedge clk);
        rst_ = 1'b1;
        quietLines(20);

        // Card initialization
        runCommand(6'd0, $random(seed), '0, 1'b0);
        arg8 = $random(seed);
        runCommand(6'd8, arg8, respOf(6'd8, {20'd0, arg8[11:0]}, 1'b0), 1'b1);
        runCommand(6'd55, 32'h0, respOf(6'd55, `SD_APP_STATUS, 1'b0), 1'b1);
        runCommand(6'd41, 32'h40FF_8000, respOf(6'h3F, `SD_OCR_READY, 1'b1), 1'b1);
        runCommand(6'd3, 32'h0, respOf(6'd3, {`SD_CARD_RCA, `SD_R6_STATUS}, 1'b0), 1'b1);
        runCommand(6'd7, {`SD_CARD_RCA, 16'h0000}, respOf(6'd7, `SD_R1_STATUS, 1'b0), 1'b1);

        // Frames the card must ignore
        frame = buildFrame(6'd8, $random(seed));
        pos   = randRange(47);
        frame[pos] = ~frame[pos];
        silentFrame(frame);
        frame    = buildFrame(6'd8, $random(seed));
        frame[0] = 1'b0;
        silentFrame(frame);
        do begin
            badIndex = randRange(64);
        end while (badIndex inside {0, 3, 7, 8, 12, 18, 55});
        runCommand(6'(badIndex), $random(seed), '0, 1'b0);
        runCommand(6'd41, 32'h40FF_8000, '0, 1'b0);
        runCommand(6'd7, {`SD_CARD_RCA ^ 16'(1 + randRange(65535)), 16'h0000}, '0, 1'b0);

        // Multi-block read ended by CMD12
        readBlocks(reads1);
        stopDuringBlock(6'd12, reads1, stop1, 1'b1);
        quietLines(16);

        // Multi-block read ended by CMD0, which also drops the RCA
        readBlocks(reads2);
        stopDuringBlock(6'd0, reads2, stop2, 1'b0);
        quietLines(16);
        runCommand(6'd7, {`SD_CARD_RCA, 16'h0000}, '0, 1'b0);
        runCommand(6'd3, 32'h0, respOf(6'd3, {`SD_CARD_RCA, `SD_R6_STATUS}, 1'b0), 1'b1);
        runCommand(6'd7, {`SD_CARD_RCA, 16'h0000}, respOf(6'd7, `SD_R1_STATUS, 1'b0), 1'b1);

        $display("Simulation finished: PASS");
        $finish;
    end

    // Watchdog sized from the planned commands and blocks
    initial begin
        wait (budget != 0);
        #(2 * budget * CLK_PERIOD);
        failRun($sformatf("Watchdog expired after %0d cycles before the test sequence ended",
                          2 * budget));
    end

endmodule

/* verilog.f */
+incdir+logic
logic/sdCardPkg.sv
logic/crc7.sv
logic/crc16Lanes.sv
logic/cmdReceiver.sv
logic/cmdResponder.sv
logic/respTransmitter.sv
logic/readBlockSender.sv
logic/sdCardEmulator.sv
test/sdCardEmulatorTb.sv
